//--- hw/sfifo_storage_pkg.sv
// Shared storage sizing. DEPTH must be a power of two of at least 2, and count_t spans 0 to DEPTH.
package sfifo_storage_pkg;

  // Number of entries in the shared data RAM, which all logical FIFOs draw from.
  localparam int DEPTH = 16;

  // Width of one item as it enters the push port and leaves a pop port.
  localparam int DATA_W = 16;

  // Bits needed to address one entry of the shared RAM.
  localparam int ENTRY_W = $clog2(DEPTH);

  // Bits needed to count from zero up to a completely full RAM.
  localparam int COUNT_W = $clog2(DEPTH + 1);

  // Index of one entry in the shared RAM and in the next-pointer array.
  typedef logic [ENTRY_W-1:0] entry_t;

  // One item of payload.
  typedef logic [DATA_W-1:0] data_t;

  // Number of items held in one FIFO's linked list in RAM.
  // A single FIFO may own every entry, so the range includes DEPTH.
  typedef logic [COUNT_W-1:0] count_t;

endpackage

//--- hw/sfifo_queue_pkg.sv
// Logical FIFO set. NUM_FIFOS is at least 2, and mask bit i always belongs to FIFO i.
package sfifo_queue_pkg;

  // Number of logical FIFOs that share the storage.
  localparam int NUM_FIFOS = 4;

  // Bits needed to name one logical FIFO.
  localparam int FIFO_IDX_W = $clog2(NUM_FIFOS);

  // Selects one logical FIFO, for example on the push port.
  typedef logic [FIFO_IDX_W-1:0] fifo_idx_t;

  // One bit per logical FIFO, used for per-FIFO valid, ready and status flags.
  typedef logic [NUM_FIFOS-1:0] fifo_mask_t;

endpackage

//--- hw/sfifo_freelist.sv
// Offers the lowest free entry; alloc_take must only rise with alloc_valid and never on a freed entry.
`timescale 1ns/1ns

module sfifo_freelist (
  input  logic                      clk,
  input  logic                      rst_n,
  output logic                      alloc_valid,
  output sfifo_storage_pkg::entry_t alloc_entry,
  input  logic                      alloc_take,
  input  logic                      dealloc_valid,
  input  sfifo_storage_pkg::entry_t dealloc_entry
);

  import sfifo_storage_pkg::*;

  // One bit per shared entry. A set bit means the entry holds no live item.
  logic [DEPTH-1:0] free_q;

  // An entry can be handed out as long as any bit is still set.
  assign alloc_valid = |free_q;

  // Priority encoder toward the lowest index.
  // Scanning downward lets the last hit, which is the lowest set bit, win.
  always_comb begin
    alloc_entry = '0;
    for (int e = DEPTH - 1; e >= 0; e--) begin
      if (free_q[e]) begin
        alloc_entry = entry_t'(e);
      end
    end
  end

  // After reset every entry is free.
  // An allocation and a deallocation in the same cycle always name different
  // entries, since the freed entry is in use and the offered one is not.
  // A freed entry is therefore offered again no earlier than the next cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      free_q <= '1;
    end else begin
      if (alloc_take) begin
        free_q[alloc_entry] <= 1'b0;
      end
      if (dealloc_valid) begin
        free_q[dealloc_entry] <= 1'b1;
      end
    end
  end

endmodule

//--- hw/sfifo_data_ram.sv
// Flop-based RAM with one write and one read port; a read returns data one cycle after rd_valid.
`timescale 1ns/1ns

module sfifo_data_ram (
  input  logic                      clk,
  input  logic                      wr_en,
  input  sfifo_storage_pkg::entry_t wr_entry,
  input  sfifo_storage_pkg::data_t  wr_data,
  input  logic                      rd_valid,
  input  sfifo_storage_pkg::entry_t rd_entry,
  output sfifo_storage_pkg::data_t  rd_data
);

  import sfifo_storage_pkg::*;

  // Item storage, one word per shared entry.
  data_t mem [DEPTH];

  // Synchronous write of the pushed item into its freshly allocated entry.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_entry] <= wr_data;
    end
  end

  // Registered read port.
  // The output holds its last value when no read is issued, so the pop
  // controller only samples it in the cycle after a granted read.
  // A read and a write in the same cycle never target the same entry,
  // because the entry being read is still allocated.
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      rd_data <= mem[rd_entry];
    end
  end

endmodule

//--- hw/sfifo_linked_list.sv
// Per-FIFO linked lists over the shared entries; head_ready must only rise with head_valid.
`timescale 1ns/1ns

module sfifo_linked_list (
  input  logic                                                       clk,
  input  logic                                                       rst_n,
  input  logic                                                       link_valid,
  input  sfifo_queue_pkg::fifo_idx_t                                 link_fifo,
  input  sfifo_storage_pkg::entry_t                                  link_entry,
  output sfifo_queue_pkg::fifo_mask_t                                head_valid,
  input  sfifo_queue_pkg::fifo_mask_t                                head_ready,
  output sfifo_storage_pkg::entry_t [sfifo_queue_pkg::NUM_FIFOS-1:0] head,
  output sfifo_storage_pkg::count_t [sfifo_queue_pkg::NUM_FIFOS-1:0] ram_items
);

  import sfifo_storage_pkg::*;
  import sfifo_queue_pkg::*;

  // Oldest and newest entry of each list, and the number of entries in it.
  // Head and tail are only meaningful while the count is nonzero.
  entry_t     head_q  [NUM_FIFOS];
  entry_t     tail_q  [NUM_FIFOS];
  count_t     count_q [NUM_FIFOS];
  // Successor of each entry within whichever list currently owns it.
  entry_t     next_q  [DEPTH];
  fifo_mask_t link_mask;
  fifo_mask_t head_fire;

  // Decode the link request into one bit per FIFO.
  assign link_mask = link_valid ? (fifo_mask_t'(1) << link_fifo) : '0;
  // A head handshake removes the head entry from its list.
  assign head_fire = head_valid & head_ready;

  for (genvar i = 0; i < NUM_FIFOS; i++) begin : gen_status
    assign head_valid[i] = (count_q[i] != '0);
    assign head[i]       = head_q[i];
    assign ram_items[i]  = count_q[i];
  end

  // Counts are control state. A link and a head handshake on the same FIFO
  // in the same cycle cancel out.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int f = 0; f < NUM_FIFOS; f++) begin
        count_q[f] <= '0;
      end
    end else begin
      for (int f = 0; f < NUM_FIFOS; f++) begin
        count_q[f] <= count_q[f] + count_t'(link_mask[f]) - count_t'(head_fire[f]);
      end
    end
  end

  // Head and tail pointers.
  // The new entry becomes the head when the list is empty, or when its only
  // entry leaves at the same edge, since the old next pointer is not yet set.
  always_ff @(posedge clk) begin
    for (int f = 0; f < NUM_FIFOS; f++) begin
      if (link_mask[f]) begin
        tail_q[f] <= link_entry;
      end
      if (link_mask[f] && ((count_q[f] == '0) || ((count_q[f] == count_t'(1)) && head_fire[f])))
      begin
        head_q[f] <= link_entry;
      end else if (head_fire[f]) begin
        head_q[f] <= next_q[head_q[f]];
      end
    end
  end

  // Chain the new entry behind the current tail.
  // An empty list has a stale tail that may now belong to another list, so it is left alone.
  always_ff @(posedge clk) begin
    if (link_valid && (count_q[link_fifo] != '0)) begin
      next_q[tail_q[link_fifo]] <= link_entry;
    end
  end

endmodule

//--- hw/sfifo_push_ctrl.sv
// Single push port; a push is taken whenever the freelist has an entry, whatever the target FIFO holds.
`timescale 1ns/1ns

module sfifo_push_ctrl (
  input  logic                       push_valid,
  output logic                       push_ready,
  input  sfifo_queue_pkg::fifo_idx_t push_fifo,
  input  sfifo_storage_pkg::data_t   push_data,
  input  logic                       alloc_valid,
  input  sfifo_storage_pkg::entry_t  alloc_entry,
  output logic                       alloc_take,
  output logic                       wr_en,
  output sfifo_storage_pkg::entry_t  wr_entry,
  output sfifo_storage_pkg::data_t   wr_data,
  output logic                       link_valid,
  output sfifo_queue_pkg::fifo_idx_t link_fifo,
  output sfifo_storage_pkg::entry_t  link_entry
);

  logic push_fire;

  // The only limit on pushing is a free entry in the shared RAM.
  // There is no per-FIFO quota, so one FIFO may fill the whole RAM.
  assign push_ready = alloc_valid;

  // A push is accepted on an edge where valid and ready are both high.
  assign push_fire = push_valid && push_ready;

  // Claim the offered entry at the same edge the push is accepted.
  assign alloc_take = push_fire;

  // The item lands in the claimed entry right away.
  // The pop side cannot see the entry before the next cycle, so its read
  // always follows this write.
  assign wr_en    = push_fire;
  assign wr_entry = alloc_entry;
  assign wr_data  = push_data;

  // Append the same entry to the tail of the chosen FIFO's list.
  assign link_valid = push_fire;
  assign link_fifo  = push_fifo;
  assign link_entry = alloc_entry;

endmodule

//--- hw/sfifo_pop_ctrl.sv
// Round-robin head reads into per-FIFO staging buffers; staging_depth must be 1 or more.
`timescale 1ns/1ns

module sfifo_pop_ctrl #(
  // Entries per staging buffer. More entries allow more reads in flight.
  parameter int staging_depth = 2
) (
  input  logic                                                       clk,
  input  logic                                                       rst_n,
  input  sfifo_queue_pkg::fifo_mask_t                                head_valid,
  output sfifo_queue_pkg::fifo_mask_t                                head_ready,
  input  sfifo_storage_pkg::entry_t [sfifo_queue_pkg::NUM_FIFOS-1:0] head,
  input  sfifo_storage_pkg::count_t [sfifo_queue_pkg::NUM_FIFOS-1:0] ram_items,
  output logic                                                       rd_valid,
  output sfifo_storage_pkg::entry_t                                  rd_entry,
  input  sfifo_storage_pkg::data_t                                   rd_data,
  output logic                                                       dealloc_valid,
  output sfifo_storage_pkg::entry_t                                  dealloc_entry,
  output sfifo_queue_pkg::fifo_mask_t                                pop_valid,
  input  sfifo_queue_pkg::fifo_mask_t                                pop_ready,
  output sfifo_storage_pkg::data_t [sfifo_queue_pkg::NUM_FIFOS-1:0]  pop_data,
  output sfifo_queue_pkg::fifo_mask_t                                pop_empty
);

  import sfifo_storage_pkg::*;
  import sfifo_queue_pkg::*;

  // Slot pointer width, kept at one bit for a single-entry buffer.
  localparam int SLOT_W = (staging_depth > 1) ? $clog2(staging_depth) : 1;
  // Occupancy counter width, covering zero up to a full buffer.
  localparam int CNT_W  = $clog2(staging_depth + 1);

  fifo_mask_t req;
  fifo_mask_t grant;
  logic       grant_any;
  fifo_idx_t  grant_idx;
  fifo_idx_t  rr_last_q;
  // The RAM has a single read port with latency one, so at most one read is in flight.
  logic       rd_pending_q;
  fifo_idx_t  rd_tag_q;

  // Round-robin pick, starting just after the FIFO granted last.
  always_comb begin
    int cand;
    grant_any = 1'b0;
    grant_idx = '0;
    for (int k = 1; k <= NUM_FIFOS; k++) begin
      cand = (int'(rr_last_q) + k) % NUM_FIFOS;
      if (!grant_any && req[cand]) begin
        grant_any = 1'b1;
        grant_idx = fifo_idx_t'(cand);
      end
    end
  end

  assign grant = grant_any ? (fifo_mask_t'(1) << grant_idx) : '0;

  // A grant is three things at once: the head handshake, the RAM read and
  // the release of the entry. The read captures the data at the same edge
  // the entry is freed, so a later reuse of the entry cannot disturb it.
  assign head_ready    = grant;
  assign rd_valid      = grant_any;
  assign rd_entry      = head[grant_idx];
  assign dealloc_valid = grant_any;
  assign dealloc_entry = head[grant_idx];

  // Arbiter pointer and read tag. The tag steers the returning data.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rr_last_q    <= fifo_idx_t'(NUM_FIFOS - 1);
      rd_pending_q <= 1'b0;
    end else begin
      rd_pending_q <= grant_any;
      if (grant_any) begin
        rr_last_q <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_any) begin
      rd_tag_q <= grant_idx;
    end
  end

  for (genvar i = 0; i < NUM_FIFOS; i++) begin : gen_stage
    data_t             stage_mem [staging_depth];
    logic [SLOT_W-1:0] wr_ptr_q;
    logic [SLOT_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0]  cnt_q;
    logic [CNT_W:0]    occupancy;
    logic              in_flight;
    logic              drain;

    // Data from the RAM arrives for this FIFO in the cycle after its grant.
    assign in_flight = rd_pending_q && (rd_tag_q == fifo_idx_t'(i));
    assign drain     = pop_valid[i] && pop_ready[i];

    // Request a read only if staged plus in-flight items leave room.
    // A stalled consumer thus leaves its items in the RAM list.
    assign occupancy = {1'b0, cnt_q} + (CNT_W + 1)'(in_flight);
    assign req[i]    = head_valid[i] && (occupancy < (CNT_W + 1)'(staging_depth));

    assign pop_valid[i] = (cnt_q != '0);
    assign pop_data[i]  = stage_mem[rd_ptr_q];
    // Empty only when nothing is left anywhere along the path.
    assign pop_empty[i] = (ram_items[i] == '0) && (cnt_q == '0) && !in_flight;

    // Circular buffer pointers and occupancy.
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (in_flight) begin
          wr_ptr_q <= (wr_ptr_q == SLOT_W'(staging_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (drain) begin
          rd_ptr_q <= (rd_ptr_q == SLOT_W'(staging_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        cnt_q <= cnt_q + CNT_W'(in_flight) - CNT_W'(drain);
      end
    end

    always_ff @(posedge clk) begin
      if (in_flight) begin
        stage_mem[wr_ptr_q] <= rd_data;
      end
    end
  end

endmodule

//--- hw/sfifo_top.sv
// Shared multi-FIFO top; pop latency is 3 cycles on an idle FIFO and grows under read contention.
`timescale 1ns/1ns

module sfifo_top #(
  // Per-FIFO staging entries, passed to the pop controller.
  parameter int staging_depth = 2
) (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      push_valid,
  output logic                                                      push_ready,
  input  sfifo_queue_pkg::fifo_idx_t                                push_fifo,
  input  sfifo_storage_pkg::data_t                                  push_data,
  output sfifo_queue_pkg::fifo_mask_t                               pop_valid,
  input  sfifo_queue_pkg::fifo_mask_t                               pop_ready,
  output sfifo_storage_pkg::data_t [sfifo_queue_pkg::NUM_FIFOS-1:0] pop_data,
  output sfifo_queue_pkg::fifo_mask_t                               pop_empty
);

  import sfifo_storage_pkg::*;
  import sfifo_queue_pkg::*;

  // Freelist to push controller.
  logic       alloc_valid;
  entry_t     alloc_entry;
  logic       alloc_take;
  // Push controller to data RAM and linked list.
  logic       wr_en;
  entry_t     wr_entry;
  data_t      wr_data;
  logic       link_valid;
  fifo_idx_t  link_fifo;
  entry_t     link_entry;
  // Linked list to pop controller.
  fifo_mask_t head_valid;
  fifo_mask_t head_ready;
  entry_t [NUM_FIFOS-1:0] head;
  count_t [NUM_FIFOS-1:0] ram_items;
  // Pop controller to data RAM and freelist.
  logic       rd_valid;
  entry_t     rd_entry;
  data_t      rd_data;
  logic       dealloc_valid;
  entry_t     dealloc_entry;

  sfifo_freelist u_freelist (
    .clk, .rst_n, .alloc_valid, .alloc_entry, .alloc_take, .dealloc_valid, .dealloc_entry
  );

  sfifo_push_ctrl u_push_ctrl (
    .push_valid, .push_ready, .push_fifo, .push_data,
    .alloc_valid, .alloc_entry, .alloc_take,
    .wr_en, .wr_entry, .wr_data,
    .link_valid, .link_fifo, .link_entry
  );

  sfifo_data_ram u_data_ram (
    .clk, .wr_en, .wr_entry, .wr_data, .rd_valid, .rd_entry, .rd_data
  );

  sfifo_linked_list u_linked_list (
    .clk, .rst_n, .link_valid, .link_fifo, .link_entry,
    .head_valid, .head_ready, .head, .ram_items
  );

  sfifo_pop_ctrl #(
    .staging_depth(staging_depth)
  ) u_pop_ctrl (
    .clk, .rst_n, .head_valid, .head_ready, .head, .ram_items,
    .rd_valid, .rd_entry, .rd_data, .dealloc_valid, .dealloc_entry,
    .pop_valid, .pop_ready, .pop_data, .pop_empty
  );

endmodule

//--- bench/sfifo_tb.sv
// Testbench for sfifo_top; STAGING must equal the staging_depth of the DUT instance.
`timescale 1ns/1ns

module sfifo_tb;

  import sfifo_storage_pkg::*;
  import sfifo_queue_pkg::*;

  localparam int STAGING  = 2;
  localparam int TIMEOUT  = 200;
  localparam int OP_PUSH  = 0;
  localparam int OP_POP   = 1;
  localparam int OP_EMPTY = 2;

  logic                  clk;
  logic                  rst_n;
  logic                  push_valid;
  logic                  push_ready;
  fifo_idx_t             push_fifo;
  data_t                 push_data;
  fifo_mask_t            pop_valid;
  fifo_mask_t            pop_ready;
  data_t [NUM_FIFOS-1:0] pop_data;
  fifo_mask_t            pop_empty;

  // One reference queue per logical FIFO, holding every item pushed but not yet popped.
  data_t      model_q [NUM_FIFOS][$];
  // Directed test table, one entry per row in each column.
  string      row_name [$];
  int         row_op   [$];
  fifo_idx_t  row_fifo [$];
  data_t      row_data [$];
  fifo_mask_t row_rdy  [$];
  // Transfers that the coming rising edge completes, as seen at the falling edge.
  logic       push_fired;
  fifo_mask_t pop_fired;
  logic [31:0] rng;

  sfifo_top #(.staging_depth(STAGING)) uut (
    .clk, .rst_n, .push_valid, .push_ready, .push_fifo, .push_data,
    .pop_valid, .pop_ready, .pop_data, .pop_empty
  );

  always #10 clk = ~clk;

  task automatic report_error(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      report_error($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_error($sformatf("Error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input count_t exp, input count_t act);
    if (act !== exp) begin
      report_error($sformatf("Error %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // 32-bit xorshift with shifts 13, 17 and 5.
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_row(input string name, input int op, input fifo_idx_t f, input data_t d,
                         input fifo_mask_t rdy);
    row_name.push_back(name);
    row_op.push_back(op);
    row_fifo.push_back(f);
    row_data.push_back(d);
    row_rdy.push_back(rdy);
  endtask

  // Drives one cycle at the rising edge, then at the falling edge checks the
  // outputs and books the transfers that the next rising edge completes.
  // pop_empty is checked before the booking, so it must match the model exactly.
  task automatic run_cycle(input string name, input logic pv, input fifo_idx_t pf,
                           input data_t pd, input fifo_mask_t rdy);
    @(posedge clk);
    push_valid <= pv;
    push_fifo  <= pf;
    push_data  <= pd;
    pop_ready  <= rdy;
    @(negedge clk);
    pop_fired = '0;
    for (int i = 0; i < NUM_FIFOS; i++) begin
      check_bit($sformatf("%s pop_empty[%0d]", name, i), model_q[i].size() == 0, pop_empty[i]);
      if (pop_valid[i] && (model_q[i].size() == 0)) begin
        report_error($sformatf("FIFO %0d raised pop_valid with no item left to pop", i));
      end
      if (pop_valid[i] && pop_ready[i]) begin
        check_data($sformatf("%s pop_data[%0d]", name, i), model_q[i][0], pop_data[i]);
        void'(model_q[i].pop_front());
        pop_fired[i] = 1'b1;
      end
    end
    push_fired = push_valid && push_ready;
    if (push_fired) begin
      model_q[push_fifo].push_back(push_data);
    end
  endtask

  // Holds the push stable until it is accepted.
  task automatic push_item(input string name, input fifo_idx_t f, input data_t d,
                           input fifo_mask_t rdy);
    for (int n = 0; n < TIMEOUT; n++) begin
      run_cycle(name, 1'b1, f, d, rdy);
      if (push_fired) break;
    end
    if (!push_fired) report_error($sformatf("%s: push_ready never rose", name));
  endtask

  task automatic pop_item(input string name, input fifo_idx_t f, input fifo_mask_t rdy);
    for (int n = 0; n < TIMEOUT; n++) begin
      run_cycle(name, 1'b0, '0, '0, rdy);
      if (pop_fired[f]) break;
    end
    if (!pop_fired[f]) report_error($sformatf("%s: pop_valid of FIFO %0d never rose", name, f));
  endtask

  // Pops every FIFO until the model is empty, then lets pop_empty settle for one check.
  task automatic drain_all(input string name);
    int left;
    left = 1;
    for (int n = 0; (n < TIMEOUT) && (left != 0); n++) begin
      run_cycle(name, 1'b0, '0, '0, '1);
      left = 0;
      for (int i = 0; i < NUM_FIFOS; i++) left += model_q[i].size();
    end
    if (left != 0) report_error($sformatf("%s: FIFOs still held items after the timeout", name));
    run_cycle(name, 1'b0, '0, '0, '1);
  endtask

  initial begin
    logic      pend;
    fifo_idx_t rf;
    data_t     rd;
    int        fill;
    clk         = 1'b0;
    rst_n       = 1'b0;
    push_valid  = 1'b0;
    push_fifo   = '0;
    push_data   = '0;
    pop_ready   = '0;

    // Order within FIFO 1, then FIFO 3 held while the others drain.
    add_row("order_push0", OP_PUSH, 2'd1, 16'h1111, 4'b0000);
    add_row("order_push1", OP_PUSH, 2'd1, 16'h1222, 4'b0000);
    add_row("order_push2", OP_PUSH, 2'd1, 16'h1333, 4'b0000);
    add_row("order_pop0", OP_POP, 2'd1, 16'h0000, 4'b0010);
    add_row("order_pop1", OP_POP, 2'd1, 16'h0000, 4'b0010);
    add_row("order_pop2", OP_POP, 2'd1, 16'h0000, 4'b0010);
    add_row("order_empty", OP_EMPTY, 2'd1, 16'h0000, 4'b0000);
    add_row("indep_push0", OP_PUSH, 2'd0, 16'h2001, 4'b0000);
    add_row("indep_push1", OP_PUSH, 2'd1, 16'h2102, 4'b0000);
    add_row("indep_push2", OP_PUSH, 2'd2, 16'h2203, 4'b0000);
    add_row("indep_push3", OP_PUSH, 2'd3, 16'h2304, 4'b0000);
    add_row("indep_push4", OP_PUSH, 2'd0, 16'h2005, 4'b0000);
    add_row("indep_push5", OP_PUSH, 2'd3, 16'h2306, 4'b0000);
    add_row("indep_pop0", OP_POP, 2'd0, 16'h0000, 4'b0001);
    add_row("indep_pop1", OP_POP, 2'd0, 16'h0000, 4'b0001);
    add_row("indep_pop2", OP_POP, 2'd1, 16'h0000, 4'b0010);
    add_row("indep_pop3", OP_POP, 2'd2, 16'h0000, 4'b0100);
    add_row("indep_empty0", OP_EMPTY, 2'd0, 16'h0000, 4'b0000);
    add_row("indep_held0", OP_POP, 2'd3, 16'h0000, 4'b1000);
    add_row("indep_held1", OP_POP, 2'd3, 16'h0000, 4'b1000);
    add_row("indep_empty3", OP_EMPTY, 2'd3, 16'h0000, 4'b0000);

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("reset_push_ready", 1'b1, push_ready);
    for (int i = 0; i < NUM_FIFOS; i++) begin
      check_bit($sformatf("reset_pop_valid[%0d]", i), 1'b0, pop_valid[i]);
      check_bit($sformatf("reset_pop_empty[%0d]", i), 1'b1, pop_empty[i]);
    end

    for (int r = 0; r < row_name.size(); r++) begin
      if (row_op[r] == OP_PUSH) begin
        push_item(row_name[r], row_fifo[r], row_data[r], row_rdy[r]);
      end else if (row_op[r] == OP_POP) begin
        pop_item(row_name[r], row_fifo[r], row_rdy[r]);
      end else begin
        run_cycle(row_name[r], 1'b0, '0, '0, row_rdy[r]);
        check_bit(row_name[r], 1'b1, pop_empty[row_fifo[r]]);
      end
    end

    // With its consumer stalled, FIFO 0 fills its staging buffer and then every RAM entry.
    // One attempt more than the full capacity shows any push taken beyond it.
    fill = 0;
    rd   = 16'hc000;
    for (int n = 0; n <= DEPTH + STAGING; n++) begin
      run_cycle("capacity_fill", 1'b1, 2'd0, rd, 4'b0000);
      if (!push_fired) break;
      fill++;
      rd++;
    end
    check_count("capacity_fill", count_t'(DEPTH + STAGING), count_t'(fill));
    // One pop frees a staging slot, so a read releases an entry and the held push goes in.
    run_cycle("capacity_pop", 1'b1, 2'd0, rd, 4'b0001);
    check_bit("capacity_pop", 1'b1, pop_fired[0]);
    // The pop is only offered in this cycle, so the RAM is still full.
    check_bit("capacity_full", 1'b0, push_ready);
    push_item("capacity_resume", 2'd0, rd, 4'b0000);
    drain_all("capacity_drain");

    // Random traffic. A started push stays on the port until it is taken.
    rng  = 32'd77;
    pend = 1'b0;
    rf   = '0;
    rd   = '0;
    for (int c = 0; c < 2000; c++) begin
      rng = xorshift(rng);
      if (!pend && rng[0]) begin
        pend = 1'b1;
        rf   = fifo_idx_t'(rng[9:8]);
        rd   = rng[31:16];
      end
      run_cycle("random", pend, rf, rd, fifo_mask_t'(rng[7:4]));
      if (push_fired) pend = 1'b0;
    end
    drain_all("random_drain");
    check_bit("final_push_ready", 1'b1, push_ready);

    $display("Verification passed");
    $finish;
  end

endmodule

//--- files.f
hw/sfifo_storage_pkg.sv
hw/sfifo_queue_pkg.sv
hw/sfifo_freelist.sv
hw/sfifo_data_ram.sv
hw/sfifo_linked_list.sv
hw/sfifo_push_ctrl.sv
hw/sfifo_pop_ctrl.sv
hw/sfifo_top.sv
bench/sfifo_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and searches the log for the pass message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module sfifo_tb -f files.f -o sfifo_sim

./obj_dir/sfifo_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi
